//--- filelist.f
verilog/lsu_pkg.sv
verilog/lsu.sv
verilog/axil_data_ram.sv
verilog/lsu_subsys_top.sv
tb/tb_lsu_subsys.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_lsu_subsys
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   List the targets"
	@echo "  test   Build with Verilator, run the testbench and check the log"
	@echo "  clean  Remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/lsu_vectors.hex
// op _ rd _ op1 address _ op2 store data _ flush _ expected res _ expected fault _ expected fence_i
// All fields hex, op encoding as in lsu_pkg (LB 0 .. SD a, FENCE b, FENCE_I c).
a_01_0000000000000100_1122334455667788_0_0000000000000000_0_0 // SD fills the word.
7_02_0000000000000103_ffffffffffffffab_0_0000000000000000_0_0
8_03_0000000000000106_000000000000cdef_0_0000000000000000_0_0
3_04_0000000000000100_0000000000000000_0_cdef3344ab667788_0_0 // Merged bytes.
9_05_0000000000000104_0000000099aabbcc_0_0000000000000000_0_0
8_06_0000000000000100_0000000000001357_0_0000000000000000_0_0
3_07_0000000000000100_0000000000000000_0_99aabbccab661357_0_0
a_08_0000000000000108_80f1e2d3c4b5a697_0_0000000000000000_0_0
0_09_0000000000000108_0000000000000000_0_ffffffffffffff97_0_0 // Sign extension.
4_0a_0000000000000108_0000000000000000_0_0000000000000097_0_0
0_0b_000000000000010d_0000000000000000_0_ffffffffffffffe2_0_0
1_0c_000000000000010e_0000000000000000_0_ffffffffffff80f1_0_0
5_0d_000000000000010e_0000000000000000_0_00000000000080f1_0_0
2_0e_0000000000000108_0000000000000000_0_ffffffffc4b5a697_0_0
6_0f_000000000000010c_0000000000000000_0_0000000080f1e2d3_0_0
1_10_000000000000010a_0000000000000000_0_ffffffffffffc4b5_0_0
0_11_0000000000000101_0000000000000000_0_0000000000000013_0_0
9_12_0000000000000108_0000000076543210_0_0000000000000000_0_0
2_13_0000000000000108_0000000000000000_0_0000000076543210_0_0
3_14_0000000000000108_0000000000000000_0_80f1e2d376543210_0_0
3_15_0000000100000100_0000000000000000_0_0000000000000000_1_0 // Upper bits set.
a_16_ffff000000000100_deadbeefdeadbeef_0_0000000000000000_1_0
1_17_0000000000000101_0000000000000000_0_0000000000000000_1_0 // Misaligned.
2_18_000000000000010a_0000000000000000_0_0000000000000000_1_0
3_19_0000000000000104_0000000000000000_0_0000000000000000_1_0
9_1a_0000000000000102_deadbeefdeadbeef_0_0000000000000000_1_0
a_1b_0000000000000900_deadbeefdeadbeef_0_0000000000000000_1_0 // SLVERR, aliases 0x100.
3_1c_0000000000000900_0000000000000000_0_0000000000000000_1_0
3_1d_0000000000000100_0000000000000000_0_99aabbccab661357_0_0 // Word unchanged.
b_1e_0000000000000000_0000000000000000_0_0000000000000000_0_0
c_1f_0000000000000000_0000000000000000_0_0000000000000000_0_1
3_20_0000000000000108_0000000000000000_1_0000000000000000_0_0 // Flushed.
3_21_0000000000000108_0000000000000000_0_80f1e2d376543210_0_0
2_22_0000000000000100_0000000000000000_1_0000000000000000_0_0
6_23_0000000000000104_0000000000000000_0_0000000099aabbcc_0_0
7_24_000000000000010f_000000000000007e_0_0000000000000000_0_0
0_25_000000000000010f_0000000000000000_0_000000000000007e_0_0
3_26_0000000000000108_0000000000000000_0_7ef1e2d376543210_0_0
c_27_0000000000000000_0000000000000000_0_0000000000000000_0_1

//--- tb/tb_lsu_subsys.sv
`timescale 1ns/100ps

module tb_lsu_subsys;

	localparam int          TIMEOUT  = 200;             // Cycles allowed per wait loop.
	localparam int          MAX_VEC  = 64;
	localparam logic [31:0] SEED     = 32'haf48;
	localparam string       VEC_FILE = "tb/lsu_vectors.hex";

	logic                CLK;
	logic                rst_n;
	logic                issue_valid;
	logic                issue_ready;
	lsu_pkg::lsu_issue_t issue;
	logic                wb_valid;
	lsu_pkg::lsu_wb_t    wb;
	logic                fence_i;
	logic                flush;

	logic [215:0] vecs [0:MAX_VEC-1];             // One operation per entry.
	logic [31:0]  rng;

	lsu_subsys_top dut (
		.CLK(CLK), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_ready(issue_ready), .issue(issue),
		.wb_valid(wb_valid), .wb(wb), .fence_i(fence_i), .flush(flush)
	);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// A load or store goes to the bus when it is in range and aligned to its size.
	function automatic bit needs_bus(input logic [3:0] op, input logic [63:0] addr);
		logic [2:0] mask;
		case (op)
			lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: mask = 3'b000;
			lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: mask = 3'b001;
			lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: mask = 3'b011;
			lsu_pkg::LD, lsu_pkg::SD:               mask = 3'b111;
			default:                                return 1'b0;
		endcase
		return (addr[63:32] == 32'd0) && ((addr[2:0] & mask) == 3'd0);
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
			$display("Some tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped after a timeout");
	endtask

	// Inputs change and outputs are sampled 1 ns after the rising edge.
	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic run_vector(input logic [215:0] v);
		logic [3:0]  op;
		logic [63:0] addr;
		logic        bus_op;
		logic        fence_seen;
		int          gap;
		int          waited;
		op     = v[215:212];
		addr   = v[203:140];
		bus_op = needs_bus(op, addr);
		rng    = xorshift32(rng);
		gap    = int'(rng[1:0]);
		repeat (gap) next_cycle();
		waited = 0;
		while (!issue_ready) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT)
				stop_on_timeout("issue_ready");
		end
		issue.op    = lsu_pkg::lsu_op_e'(op);
		issue.rd    = v[209:204];
		issue.op1   = addr;
		issue.op2   = v[139:76];
		issue_valid = 1'b1;
		next_cycle();                              // Accepted on this edge.
		issue_valid = 1'b0;
		fence_seen  = fence_i;
		waited      = 0;
		if (v[72]) begin
			flush = 1'b1;
			check_value("wb_valid", 64'd0, 64'(wb_valid));
			next_cycle();
			flush = 1'b0;
			while (!issue_ready) begin
				check_value("wb_valid", 64'd0, 64'(wb_valid));
				next_cycle();
				waited++;
				if (waited > TIMEOUT)
					stop_on_timeout("the flushed operation to drain");
			end
			check_value("wb_valid", 64'd0, 64'(wb_valid));
		end else begin
			while (!wb_valid) begin
				if (bus_op)
					check_value("issue_ready", 64'd0, 64'(issue_ready));
				next_cycle();
				fence_seen = fence_seen | fence_i;
				waited++;
				if (waited > TIMEOUT)
					stop_on_timeout("wb_valid");
			end
			check_value("wb.res", v[71:8], wb.res);
			check_value("wb.rd", 64'(v[209:204]), 64'(wb.rd));
			check_value("wb.fault", 64'(v[4]), 64'(wb.fault));
			check_value("fence_i", 64'(v[0]), 64'(fence_seen));
			if (!bus_op)
				check_value("issue_ready", 64'd1, 64'(issue_ready));  // Fault or fence stays idle.
			next_cycle();
			check_value("wb_valid", 64'd0, 64'(wb_valid));  // One writeback only.
			check_value("fence_i", 64'd0, 64'(fence_i));    // Pulse lasts one cycle.
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		flush       = 1'b0;
		rng         = SEED;
		for (int i = 0; i < MAX_VEC; i++)
			vecs[i] = '1;                          // Op nibble f ends the list.
		$readmemh(VEC_FILE, vecs);
		repeat (16) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		for (int n = 0; n < MAX_VEC; n++) begin
			if (vecs[n][215:212] == 4'hf)
				break;
			run_vector(vecs[n]);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

//--- verilog/lsu_subsys_top.sv
`timescale 1ns/100ps

module lsu_subsys_top (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                issue_valid,
	output logic                issue_ready,
	input  lsu_pkg::lsu_issue_t issue,
	output logic                wb_valid,
	output lsu_pkg::lsu_wb_t    wb,
	output logic                fence_i,
	input  logic                flush
);

	// AXI4-Lite link between the unit and the memory.
	logic              awvalid, awready;
	logic              wvalid, wready;
	logic              bvalid, bready;
	logic              arvalid, arready;
	logic              rvalid, rready;
	lsu_pkg::axil_aw_t aw;
	lsu_pkg::axil_w_t  w;
	lsu_pkg::axil_b_t  b;
	lsu_pkg::axil_ar_t ar;
	lsu_pkg::axil_r_t  r;

	lsu u_lsu (
		.CLK(CLK), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_ready(issue_ready), .issue(issue),
		.wb_valid(wb_valid), .wb(wb), .fence_i(fence_i), .flush(flush),
		.awvalid(awvalid), .awready(awready), .aw(aw),
		.wvalid(wvalid), .wready(wready), .w(w),
		.bvalid(bvalid), .bready(bready), .b(b),
		.arvalid(arvalid), .arready(arready), .ar(ar),
		.rvalid(rvalid), .rready(rready), .r(r)
	);

	axil_data_ram u_ram (
		.CLK(CLK), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .aw(aw),
		.wvalid(wvalid), .wready(wready), .w(w),
		.bvalid(bvalid), .bready(bready), .b(b),
		.arvalid(arvalid), .arready(arready), .ar(ar),
		.rvalid(rvalid), .rready(rready), .r(r)
	);

endmodule

//--- verilog/axil_data_ram.sv
`timescale 1ns/100ps

module axil_data_ram (
	input  logic              CLK,
	input  logic              rst_n,

	input  logic              awvalid,
	output logic              awready,
	input  lsu_pkg::axil_aw_t aw,

	input  logic              wvalid,
	output logic              wready,
	input  lsu_pkg::axil_w_t  w,

	output logic              bvalid,
	input  logic              bready,
	output lsu_pkg::axil_b_t  b,

	input  logic              arvalid,
	output logic              arready,
	input  lsu_pkg::axil_ar_t ar,

	output logic              rvalid,
	input  logic              rready,
	output lsu_pkg::axil_r_t  r
);

	localparam logic [lsu_pkg::XLEN-1:0] MEM_BYTES = lsu_pkg::XLEN'(lsu_pkg::RAM_WORDS * 8);

	logic [lsu_pkg::XLEN-1:0] mem [0:lsu_pkg::RAM_WORDS-1];

	logic                      wr_go;
	logic                      rd_go;
	logic                      wr_hit;
	logic                      rd_hit;
	logic [lsu_pkg::RAM_AW-1:0] wr_idx;
	logic [lsu_pkg::RAM_AW-1:0] rd_idx;

	// AW and W are taken together, only when the B slot is free.
	assign wr_go   = awvalid & wvalid & ~bvalid;
	assign awready = wr_go;
	assign wready  = wr_go;

	assign arready = ~rvalid;
	assign rd_go   = arvalid & arready;

	assign wr_hit = (aw.addr < MEM_BYTES);
	assign rd_hit = (ar.addr < MEM_BYTES);
	assign wr_idx = aw.addr[lsu_pkg::RAM_AW+2:3];
	assign rd_idx = ar.addr[lsu_pkg::RAM_AW+2:3];

	// Strobed write.
	always_ff @(posedge CLK) begin
		if (wr_go & wr_hit) begin
			for (int i = 0; i < lsu_pkg::XLEN / 8; i++) begin
				if (w.strb[i])
					mem[wr_idx][i*8 +: 8] <= w.data[i*8 +: 8];
			end
		end
	end

	// Write response.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
		end else if (wr_go) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;                    // Held until taken.
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_go)
			b.resp <= wr_hit ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
	end

	// Read response.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rd_go) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_go) begin
			if (rd_hit) begin
				r.data <= mem[rd_idx];
				r.resp <= lsu_pkg::RESP_OKAY;
			end else begin
				r.data <= '0;                  // Out of range reads zero.
				r.resp <= lsu_pkg::RESP_SLVERR;
			end
		end
	end

endmodule

//--- verilog/lsu.sv
`timescale 1ns/100ps

module lsu (
	input  logic                CLK,
	input  logic                rst_n,

	input  logic                issue_valid,
	output logic                issue_ready,
	input  lsu_pkg::lsu_issue_t issue,

	output logic                wb_valid,
	output lsu_pkg::lsu_wb_t    wb,
	output logic                fence_i,
	input  logic                flush,

	output logic                awvalid,
	input  logic                awready,
	output lsu_pkg::axil_aw_t   aw,

	output logic                wvalid,
	input  logic                wready,
	output lsu_pkg::axil_w_t    w,

	input  logic                bvalid,
	output logic                bready,
	input  lsu_pkg::axil_b_t    b,

	output logic                arvalid,
	input  logic                arready,
	output lsu_pkg::axil_ar_t   ar,

	input  logic                rvalid,
	output logic                rready,
	input  lsu_pkg::axil_r_t    r
);

	logic op_lb, op_lh, op_lw, op_ld;
	logic op_lbu, op_lhu, op_lwu;
	logic op_sb, op_sh, op_sw, op_sd;
	logic op_fence, op_fence_i;

	logic       is_load;
	logic       is_store;
	logic       is_fence;
	logic       is_unsigned;
	logic [1:0] acc_size;                  // 0 byte, 1 half, 2 word, 3 double.
	logic [2:0] align_mask;
	logic [7:0] base_strb;

	logic range_fault;
	logic align_fault;
	logic fault_now;
	logic accept;
	logic bus_go;
	logic imm_done;

	logic busy;
	logic squashed;
	logic b_done;
	logic r_done;
	logic rsp_done;
	logic rsp_err;

	logic [lsu_pkg::TAG_W-1:0] rd_q;
	logic [1:0]                size_q;
	logic                      unsigned_q;
	logic [2:0]                lane_q;
	logic [lsu_pkg::XLEN-1:0]  rd_lane;
	logic [lsu_pkg::XLEN-1:0]  load_res;

	// Operation decode.
	assign op_lb      = (issue.op == lsu_pkg::LB);
	assign op_lh      = (issue.op == lsu_pkg::LH);
	assign op_lw      = (issue.op == lsu_pkg::LW);
	assign op_ld      = (issue.op == lsu_pkg::LD);
	assign op_lbu     = (issue.op == lsu_pkg::LBU);
	assign op_lhu     = (issue.op == lsu_pkg::LHU);
	assign op_lwu     = (issue.op == lsu_pkg::LWU);
	assign op_sb      = (issue.op == lsu_pkg::SB);
	assign op_sh      = (issue.op == lsu_pkg::SH);
	assign op_sw      = (issue.op == lsu_pkg::SW);
	assign op_sd      = (issue.op == lsu_pkg::SD);
	assign op_fence   = (issue.op == lsu_pkg::FENCE);
	assign op_fence_i = (issue.op == lsu_pkg::FENCE_I);

	assign is_load     = op_lb | op_lh | op_lw | op_ld | op_lbu | op_lhu | op_lwu;
	assign is_store    = op_sb | op_sh | op_sw | op_sd;
	assign is_fence    = op_fence | op_fence_i;
	assign is_unsigned = op_lbu | op_lhu | op_lwu;

	assign acc_size[1] = op_lw | op_lwu | op_ld | op_sw | op_sd;
	assign acc_size[0] = op_lh | op_lhu | op_ld | op_sh | op_sd;

	assign align_mask = {acc_size == 2'd3, acc_size[1], acc_size != 2'd0};
	assign base_strb  = ({8{op_sb}} & 8'h01)
	                  | ({8{op_sh}} & 8'h03)
	                  | ({8{op_sw}} & 8'h0f)
	                  | ({8{op_sd}} & 8'hff);

	// Checks on the issue word.
	assign range_fault = |issue.op1[63:32];
	assign align_fault = |(issue.op1[2:0] & align_mask);
	// Unknown encodings fault as well.
	assign fault_now   = (is_load | is_store) ? (range_fault | align_fault) : ~is_fence;

	assign issue_ready = ~busy;
	assign accept      = issue_valid & issue_ready & ~flush;
	assign bus_go      = accept & (is_load | is_store) & ~range_fault & ~align_fault;
	assign imm_done    = accept & ~bus_go;

	assign bready   = busy;                // Never stall the memory.
	assign rready   = busy;
	assign b_done   = bvalid & bready;
	assign r_done   = rvalid & rready;
	assign rsp_done = b_done | r_done;
	assign rsp_err  = b_done ? (b.resp == lsu_pkg::RESP_SLVERR) : (r.resp == lsu_pkg::RESP_SLVERR);

	// Shift the addressed lane down, then extend by size and signedness.
	assign rd_lane  = r.data >> {lane_q, 3'b000};
	assign load_res =
		({64{size_q == 2'd0}} & (unsigned_q ? {56'b0, rd_lane[7:0]} :
		                                      {{56{rd_lane[7]}}, rd_lane[7:0]}))
		|
		({64{size_q == 2'd1}} & (unsigned_q ? {48'b0, rd_lane[15:0]} :
		                                      {{48{rd_lane[15]}}, rd_lane[15:0]}))
		|
		({64{size_q == 2'd2}} & (unsigned_q ? {32'b0, rd_lane[31:0]} :
		                                      {{32{rd_lane[31]}}, rd_lane[31:0]}))
		|
		({64{size_q == 2'd3}} & rd_lane);

	// Set/reset control bits.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			squashed <= 1'b0;
			awvalid  <= 1'b0;
			wvalid   <= 1'b0;
			arvalid  <= 1'b0;
			wb_valid <= 1'b0;
			fence_i  <= 1'b0;
		end else begin
			if (bus_go)
				busy <= 1'b1;
			else if (rsp_done)
				busy <= 1'b0;

			if (rsp_done)
				squashed <= 1'b0;
			else if (busy & flush)
				squashed <= 1'b1;              // Response is dropped on arrival.

			if (bus_go & is_store)
				awvalid <= 1'b1;
			else if (awready)
				awvalid <= 1'b0;

			if (bus_go & is_store)
				wvalid <= 1'b1;
			else if (wready)
				wvalid <= 1'b0;

			if (bus_go & is_load)
				arvalid <= 1'b1;
			else if (arready)
				arvalid <= 1'b0;

			wb_valid <= imm_done | (rsp_done & ~squashed & ~flush);
			fence_i  <= accept & op_fence_i;
		end
	end

	// Request payload and response context.
	always_ff @(posedge CLK) begin
		if (bus_go) begin
			aw.addr    <= issue.op1;
			aw.prot    <= lsu_pkg::PROT_STORE;
			w.data     <= issue.op2 << {issue.op1[2:0], 3'b000};
			w.strb     <= base_strb << issue.op1[2:0];
			ar.addr    <= issue.op1;
			ar.prot    <= lsu_pkg::PROT_DATA;
			rd_q       <= issue.rd;
			size_q     <= acc_size;
			unsigned_q <= is_unsigned;
			lane_q     <= issue.op1[2:0];
		end
	end

	// Writeback word.
	always_ff @(posedge CLK) begin
		if (imm_done) begin
			wb.res   <= '0;
			wb.rd    <= issue.rd;
			wb.fault <= fault_now;
		end else if (rsp_done) begin
			wb.res   <= (r_done & ~rsp_err) ? load_res : '0;
			wb.rd    <= rd_q;
			wb.fault <= rsp_err;
		end
	end

endmodule

//--- verilog/lsu_pkg.sv
package lsu_pkg;

	localparam int XLEN      = 64;
	localparam int RB        = 1;          // Rename bits of the destination tag.
	localparam int TAG_W     = 5 + RB;
	localparam int RAM_WORDS = 256;        // Data memory depth in 64-bit words.
	localparam int RAM_AW    = 8;          // Word index width.

	localparam logic [2:0] PROT_DATA  = 3'b001;  // Loads.
	localparam logic [2:0] PROT_STORE = 3'b000;  // Stores.

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Memory operation handed over by the execute stage.
	typedef enum logic [3:0] {
		LB      = 4'd0,
		LH      = 4'd1,
		LW      = 4'd2,
		LD      = 4'd3,
		LBU     = 4'd4,
		LHU     = 4'd5,
		LWU     = 4'd6,
		SB      = 4'd7,
		SH      = 4'd8,
		SW      = 4'd9,
		SD      = 4'd10,
		FENCE   = 4'd11,
		FENCE_I = 4'd12
	} lsu_op_e;

	typedef struct packed {
		lsu_op_e           op;
		logic [TAG_W-1:0]  rd;
		logic [XLEN-1:0]   op1;   // Effective address.
		logic [XLEN-1:0]   op2;   // Store data.
	} lsu_issue_t;

	typedef struct packed {
		logic [XLEN-1:0]   res;
		logic [TAG_W-1:0]  rd;
		logic              fault;
	} lsu_wb_t;

	// AXI4-Lite channel payloads. Valid and ready travel separately.
	typedef struct packed {
		logic [XLEN-1:0]   addr;
		logic [2:0]        prot;
	} axil_aw_t;

	typedef struct packed {
		logic [XLEN-1:0]   data;
		logic [XLEN/8-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [XLEN-1:0]   addr;
		logic [2:0]        prot;
	} axil_ar_t;

	typedef struct packed {
		logic [XLEN-1:0]   data;
		logic [1:0]        resp;
	} axil_r_t;

	typedef struct packed {
		logic [1:0]        resp;
	} axil_b_t;

endpackage
